// File: ir_tracker_golden.txt
// pattern (row 0 in the top byte) x y detected count ssd
// ssd holds digits X - Y - from bit 27 down, gfedcba each
0000000000 0 0 0 00 8102040
FFFFFFFFFF 0 0 1 28 7F01FC0
0100000000 0 0 1 01 7F01FC0
0000000080 7 4 1 01 0F03340
0000240000 2 2 1 02 B702DC0
0080000100 7 1 1 02 0F00340
F0000000FF 4 0 1 0C CD01FC0
0000001800 3 3 1 02 9F027C0
0000400001 6 2 1 02 FB02DC0
0020FFFFFF 5 1 1 19 DB00340
0000000002 1 4 1 01 0D03340
A55AC33C81 0 0 1 12 7F01FC0
0000FF0000 0 2 1 08 7F02DC0
0000000100 0 3 1 01 7F027C0
FFFFFFFFFF 0 0 1 28 7F01FC0
0000000000 0 0 0 00 8102040

// File: ir_tracker.f
+incdir+.
ir_tracker_pkg.sv
ir_shift_reader.sv
ball_locator.sv
position_display.sv
ir_axil_regs.sv
ir_tracker_top.sv
tb_ir_tracker.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ir_tracker -f ir_tracker.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Result: PASSED$" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// File: tb_ir_tracker.sv
`timescale 1ns/1ps
`include "ir_tracker_config.svh"

module tb_ir_tracker;
    localparam int          NUM_VEC      = 16;
    localparam int          FRAME_CYCLES = 81 * `IR_TICK_DIV;  // Latch tick plus 40 slots
    localparam real         WATCHDOG_NS  = (NUM_VEC + 2) * 3 * FRAME_CYCLES * 8.0;
    localparam logic [27:0] DASHES       = {4{7'b1000000}};

    logic                          clk = 1'b0;
    logic                          n_rst;
    logic                          sdi = 1'b1;   // Nothing covered
    logic                          latch;
    logic                          sclk;
    logic [27:0]                   ssd;
    logic                          awvalid;
    logic [`AXIL_ADDR_W-1:0]       awaddr;
    logic                          wvalid;
    logic [`AXIL_DATA_W-1:0]       wdata;
    logic [`AXIL_DATA_W/8-1:0]     wstrb;
    logic                          awready;
    logic                          wready;
    logic                          bvalid;
    ir_tracker_pkg::axi_resp_e     bresp;
    logic                          bready;
    logic                          arvalid;
    logic [`AXIL_ADDR_W-1:0]       araddr;
    logic                          rready;
    logic                          arready;
    logic                          rvalid;
    logic [`AXIL_DATA_W-1:0]       rdata;
    ir_tracker_pkg::axi_resp_e     rresp;

    logic [39:0]                   golden [0:NUM_VEC*6-1];  // Six fields per vector
    ir_tracker_pkg::sensor_frame_u pattern;
    logic [39:0]                   chain = '0;
    logic                          sclk_seen = 1'b1;

    ir_tracker_top dut (.*);

    always #4 clk = ~clk;

    // Sensor chain model where covered sensors pull sdi low
    always @(negedge clk) begin
        if (!latch) begin
            chain <= pattern.flat;
            sdi   <= ~pattern.flat[39];
        end else if (sclk && !sclk_seen) begin
            chain <= {chain[38:0], 1'b0};   // Shift on rising sclk
            sdi   <= ~chain[38];
        end
        sclk_seen <= sclk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_frame(input ir_tracker_pkg::sensor_frame_u got,
                               input ir_tracker_pkg::sensor_frame_u exp);
        if (got.flat !== exp.flat) report_mismatch("frame", 64'(got.flat), 64'(exp.flat));
    endtask

    task automatic check_position(input logic got_det, input logic [3:0] got_x,
                                  input logic [3:0] got_y, input logic [5:0] got_cnt,
                                  input logic exp_det, input logic [3:0] exp_x,
                                  input logic [3:0] exp_y, input logic [5:0] exp_cnt);
        if (got_det !== exp_det) report_mismatch("ball_detected", 64'(got_det), 64'(exp_det));
        if (got_x !== exp_x) report_mismatch("ball_x", 64'(got_x), 64'(exp_x));
        if (got_y !== exp_y) report_mismatch("ball_y", 64'(got_y), 64'(exp_y));
        if (got_cnt !== exp_cnt) report_mismatch("sensor_count", 64'(got_cnt), 64'(exp_cnt));
    endtask

    task automatic check_ssd(input logic [27:0] got, input logic [27:0] exp);
        if (got !== exp) report_mismatch("ssd", 64'(got), 64'(exp));
    endtask

    task automatic check_resp(input string name, input ir_tracker_pkg::axi_resp_e got,
                              input ir_tracker_pkg::axi_resp_e exp);
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_word(input string name, input logic [`AXIL_DATA_W-1:0] got,
                              input logic [`AXIL_DATA_W-1:0] exp);
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr,
                             input logic [`AXIL_DATA_W-1:0] data,
                             output ir_tracker_pkg::axi_resp_e resp);
        int unsigned stall;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = '1;
        do @(negedge clk); while (!awready && !wready);   // Handshake on the next rising edge
        if (!(awready && wready)) stop_run("awready and wready were not raised together");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        stall = $urandom % 5;
        repeat (stall) @(negedge clk);
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr,
                            output logic [`AXIL_DATA_W-1:0] data,
                            output ir_tracker_pkg::axi_resp_e resp);
        int unsigned stall;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        stall = $urandom % 5;
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_run("Timeout: the run hung, the DUT stopped answering");
    end

    initial begin
        ir_tracker_pkg::sensor_frame_u got_frame;
        ir_tracker_pkg::axi_resp_e     resp;
        logic [`AXIL_DATA_W-1:0]       data;
        logic [`AXIL_DATA_W-1:0]       lo;
        logic [`AXIL_DATA_W-1:0]       hi;
        logic [`AXIL_DATA_W-1:0]       base;
        logic [`AXIL_DATA_W-1:0]       cnt;
        logic [`AXIL_DATA_W-1:0]       cnt_a;
        logic [`AXIL_DATA_W-1:0]       cnt_b;
        int                            last;
        void'($urandom(60));
        n_rst     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        pattern   <= '0;
        $readmemh("ir_tracker_golden.txt", golden);
        repeat (16) @(negedge clk);
        n_rst = 1'b1;

        // Idle after reset
        check_ssd(ssd, DASHES);
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (!latch || !sclk) stop_run("latch or sclk left the idle level while CTRL is 0");
        end
        axi_read(`REG_FRAME_CNT, cnt, resp);
        check_word("FRAME_CNT", cnt, 32'd0);

        axi_write(`REG_CTRL, 32'd1, resp);
        check_resp("bresp", resp, ir_tracker_pkg::RESP_OKAY);

        for (int v = 0; v < NUM_VEC; v++) begin
            pattern <= golden[6*v];
            axi_read(`REG_FRAME_CNT, base, resp);
            do begin
                axi_read(`REG_FRAME_CNT, cnt, resp);
            end while (cnt < base + 32'd2);   // Second frame is read fully after the change
            axi_read(`REG_FRAME_LO, lo, resp);
            axi_read(`REG_FRAME_HI, hi, resp);
            got_frame.flat = {hi[7:0], lo};
            check_frame(got_frame, golden[6*v]);
            axi_read(`REG_POS, data, resp);
            check_resp("rresp", resp, ir_tracker_pkg::RESP_OKAY);
            check_position(data[16], data[3:0], data[7:4], data[13:8], golden[6*v+3][0],
                           golden[6*v+1][3:0], golden[6*v+2][3:0], golden[6*v+4][5:0]);
            check_ssd(ssd, golden[6*v+5][27:0]);
        end

        // Error responses from the read-only POS and an unmapped address
        last = 6 * (NUM_VEC - 1);
        axi_write(`REG_POS, 32'hFFFF_FFFF, resp);
        check_resp("bresp", resp, ir_tracker_pkg::RESP_SLVERR);
        axi_read(`REG_POS, data, resp);
        check_position(data[16], data[3:0], data[7:4], data[13:8], golden[last+3][0],
                       golden[last+1][3:0], golden[last+2][3:0], golden[last+4][5:0]);
        axi_read(5'h14, data, resp);
        check_word("rdata", data, 32'd0);
        check_resp("rresp", resp, ir_tracker_pkg::RESP_SLVERR);

        // Stop scanning
        axi_write(`REG_CTRL, 32'd0, resp);
        check_resp("bresp", resp, ir_tracker_pkg::RESP_OKAY);
        axi_read(`REG_FRAME_CNT, cnt_a, resp);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        axi_read(`REG_FRAME_CNT, cnt_b, resp);
        if (cnt_b > cnt_a + 32'd1) stop_run("FRAME_CNT kept counting after CTRL was cleared");
        repeat (FRAME_CYCLES) @(negedge clk);
        axi_read(`REG_FRAME_CNT, cnt, resp);
        check_word("FRAME_CNT", cnt, cnt_b);
        if (!latch || !sclk) stop_run("latch or sclk not back at idle after scanning stopped");

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: ir_tracker_top.sv
`timescale 1ns/1ps
`include "ir_tracker_config.svh"

module ir_tracker_top (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      sdi,
    output logic                      latch,
    output logic                      sclk,
    output logic [27:0]               ssd,
    input  logic                      awvalid,
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      wvalid,
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_DATA_W/8-1:0] wstrb,
    output logic                      awready,
    output logic                      wready,
    output logic                      bvalid,
    output ir_tracker_pkg::axi_resp_e bresp,
    input  logic                      bready,
    input  logic                      arvalid,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      rready,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output ir_tracker_pkg::axi_resp_e rresp
);
    logic                          scan_en;
    logic                          frame_valid;
    ir_tracker_pkg::sensor_frame_u frame;
    logic                          result_valid;
    logic                          ball_detected;
    logic [3:0]                    ball_x;
    logic [3:0]                    ball_y;
    logic [5:0]                    sensor_count;

    ir_shift_reader u_reader (.*);

    ball_locator u_locator (.*);

    position_display u_display (.*);

    ir_axil_regs u_regs (.*);   // Host side, owns scan_en

endmodule

// File: ir_axil_regs.sv
`timescale 1ns/1ps
`include "ir_tracker_config.svh"

module ir_axil_regs (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          awvalid,
    input  logic [`AXIL_ADDR_W-1:0]       awaddr,
    input  logic                          wvalid,
    input  logic [`AXIL_DATA_W-1:0]       wdata,
    input  logic [`AXIL_DATA_W/8-1:0]     wstrb,
    output logic                          awready,
    output logic                          wready,
    output logic                          bvalid,
    output ir_tracker_pkg::axi_resp_e     bresp,
    input  logic                          bready,
    input  logic                          arvalid,
    input  logic [`AXIL_ADDR_W-1:0]       araddr,
    input  logic                          rready,
    output logic                          arready,
    output logic                          rvalid,
    output logic [`AXIL_DATA_W-1:0]       rdata,
    output ir_tracker_pkg::axi_resp_e     rresp,
    input  logic                          frame_valid,
    input  ir_tracker_pkg::sensor_frame_u frame,
    input  logic                          result_valid,
    input  logic                          ball_detected,
    input  logic [3:0]                    ball_x,
    input  logic [3:0]                    ball_y,
    input  logic [5:0]                    sensor_count,
    output logic                          scan_en
);
    logic                          wr_en;
    logic                          rd_en;
    logic                          det_q;
    logic [3:0]                    x_q;
    logic [3:0]                    y_q;
    logic [5:0]                    cnt_q;
    ir_tracker_pkg::sensor_frame_u frame_q;
    logic [`AXIL_DATA_W-1:0]       frame_cnt;
    logic [`AXIL_DATA_W-1:0]       pos_word;
    logic [`AXIL_DATA_W-1:0]       rd_data;
    ir_tracker_pkg::axi_resp_e     rd_resp;

    assign wr_en = awready && awvalid && wvalid;
    assign rd_en = arready && arvalid;

    // AW and W taken together, one write in flight
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= ir_tracker_pkg::RESP_OKAY;
            scan_en <= 1'b0;
        end else begin
            awready <= !awready && !bvalid && awvalid && wvalid;
            wready  <= !awready && !bvalid && awvalid && wvalid;
            if (wr_en) begin
                bvalid <= 1'b1;
                if (awaddr == `REG_CTRL) begin
                    bresp <= ir_tracker_pkg::RESP_OKAY;
                    if (wstrb[0]) begin
                        scan_en <= wdata[0];
                    end
                end else begin
                    bresp <= ir_tracker_pkg::RESP_SLVERR;  // Read-only or unmapped
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        pos_word = '0;
        pos_word[ir_tracker_pkg::POS_DET_BIT]                            = det_q;
        pos_word[ir_tracker_pkg::POS_CNT_LSB +: ir_tracker_pkg::POS_CNT_W] = cnt_q;
        pos_word[ir_tracker_pkg::POS_Y_LSB +: ir_tracker_pkg::POS_XY_W]    = y_q;
        pos_word[ir_tracker_pkg::POS_X_LSB +: ir_tracker_pkg::POS_XY_W]    = x_q;
    end

    // Read decode
    always_comb begin
        rd_data = '0;
        rd_resp = ir_tracker_pkg::RESP_OKAY;
        case (araddr)
            `REG_CTRL:      rd_data[0]   = scan_en;
            `REG_POS:       rd_data      = pos_word;
            `REG_FRAME_LO:  rd_data      = frame_q.flat[31:0];
            `REG_FRAME_HI:  rd_data[7:0] = frame_q.rows[0];   // Row 0 byte
            `REG_FRAME_CNT: rd_data      = frame_cnt;
            default:        rd_resp      = ir_tracker_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= ir_tracker_pkg::RESP_OKAY;
        end else begin
            arready <= !arready && !rvalid && arvalid;
            if (rd_en) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= rd_resp;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Result and frame capture, frame counter
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            det_q     <= 1'b0;
            x_q       <= '0;
            y_q       <= '0;
            cnt_q     <= '0;
            frame_q   <= '0;
            frame_cnt <= '0;
        end else begin
            if (result_valid) begin
                det_q <= ball_detected;
                x_q   <= ball_x;
                y_q   <= ball_y;
                cnt_q <= sensor_count;
            end
            if (frame_valid) begin
                frame_q   <= frame;
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!n_rst)
        rvalid && !rready |=> rvalid);

    a_b_hold: assert property (@(posedge clk) disable iff (!n_rst)
        bvalid && !bready |=> bvalid);

endmodule

// File: position_display.sv
`timescale 1ns/1ps

module position_display (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        result_valid,
    input  logic        ball_detected,
    input  logic [3:0]  ball_x,
    input  logic [3:0]  ball_y,
    output logic [27:0] ssd
);
    localparam logic [6:0] SEG_DASH = 7'b1000000;  // Segment g only

    // gfedcba, active high
    function automatic logic [6:0] seg_code(input logic [3:0] digit);
        case (digit)
            4'd0:    seg_code = 7'b0111111;
            4'd1:    seg_code = 7'b0000110;
            4'd2:    seg_code = 7'b1011011;
            4'd3:    seg_code = 7'b1001111;
            4'd4:    seg_code = 7'b1100110;
            4'd5:    seg_code = 7'b1101101;
            4'd6:    seg_code = 7'b1111101;
            4'd7:    seg_code = 7'b0000111;
            default: seg_code = SEG_DASH;   // Off the board
        endcase
    endfunction

    // Digits left to right: X, dash, Y, dash
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ssd <= {4{SEG_DASH}};
        end else if (result_valid) begin
            if (ball_detected) begin
                ssd <= {seg_code(ball_x), SEG_DASH, seg_code(ball_y), SEG_DASH};
            end else begin
                ssd <= {4{SEG_DASH}};   // No ball
            end
        end
    end

endmodule

// File: ball_locator.sv
`timescale 1ns/1ps
`include "ir_tracker_config.svh"

module ball_locator (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          frame_valid,
    input  ir_tracker_pkg::sensor_frame_u frame,
    output logic                          result_valid,
    output logic                          ball_detected,
    output logic [3:0]                    ball_x,
    output logic [3:0]                    ball_y,
    output logic [5:0]                    sensor_count
);
    logic       found;
    logic [3:0] x_n;
    logic [3:0] y_n;
    logic [5:0] cnt_n;

    // First covered sensor, row 0 first, column 0 first within a row
    always_comb begin
        found = 1'b0;
        x_n   = '0;
        y_n   = '0;
        for (int r = 0; r < `IR_ROWS; r++) begin
            for (int c = 0; c < `IR_COLS; c++) begin
                if (!found && frame.rows[r][c]) begin
                    found = 1'b1;
                    x_n   = 4'(c);
                    y_n   = 4'(r);
                end
            end
        end
    end

    // Population count over the whole frame
    always_comb begin
        cnt_n = '0;
        for (int i = 0; i < `IR_BITS; i++) begin
            cnt_n = cnt_n + 6'(frame.flat[i]);
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= frame_valid;
        end
    end

    // Results only mean something alongside result_valid
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            ball_detected <= found;
            ball_x        <= x_n;
            ball_y        <= y_n;
            sensor_count  <= cnt_n;
        end
    end

    // Encoder and counter are separate paths, they must agree
    a_det_count: assert property (@(posedge clk) disable iff (!n_rst)
        result_valid |-> (ball_detected == (sensor_count != 6'd0)));

endmodule

// File: ir_shift_reader.sv
`timescale 1ns/1ps
`include "ir_tracker_config.svh"

module ir_shift_reader (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          scan_en,
    input  logic                          sdi,
    output logic                          latch,
    output logic                          sclk,
    output logic                          frame_valid,
    output ir_tracker_pkg::sensor_frame_u frame
);
    localparam int         DIV_W    = $clog2(`IR_TICK_DIV);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;  // latch low, chain loads
    localparam logic [1:0] ST_SHIFT = 2'd2;
    localparam logic [5:0] LAST_BIT = 6'(`IR_BITS - 1);

    logic [DIV_W-1:0]    div_cnt;
    logic                tick;
    logic [1:0]          state;
    logic [5:0]          bit_cnt;    // Slot index, 0 is frame bit 39
    logic [`IR_BITS-1:0] shift_q;
    logic                sample;
    logic                done;

    assign tick = (div_cnt == DIV_W'(`IR_TICK_DIV - 1));

    // Tick prescaler
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // sclk doubles as the slot phase: low tick samples, high tick shifts
    assign sample = tick && (state == ST_SHIFT) && !sclk;
    assign done   = tick && (state == ST_SHIFT) && sclk && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state       <= ST_IDLE;
            bit_cnt     <= '0;
            latch       <= 1'b1;
            sclk        <= 1'b1;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= done;
            if (tick) begin
                case (state)
                    ST_IDLE: begin
                        if (scan_en) begin
                            state <= ST_LOAD;
                            latch <= 1'b0;
                        end
                    end
                    ST_LOAD: begin
                        state   <= ST_SHIFT;
                        latch   <= 1'b1;
                        sclk    <= 1'b0;
                        bit_cnt <= '0;
                    end
                    ST_SHIFT: begin
                        if (!sclk) begin
                            sclk <= 1'b1;             // Chain shifts on this edge
                        end else if (done) begin
                            // Back to back while enabled
                            state <= scan_en ? ST_LOAD : ST_IDLE;
                            latch <= !scan_en;
                        end else begin
                            sclk    <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Sensors pull sdi low when covered
    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= {shift_q[`IR_BITS-2:0], ~sdi};
        end
        if (done) begin
            frame.flat <= shift_q;
        end
    end

    // The chain must never see a load while the clock is low
    a_latch_sclk: assert property (@(posedge clk) disable iff (!n_rst)
        latch || sclk);

    a_bit_cnt: assert property (@(posedge clk) disable iff (!n_rst)
        bit_cnt <= LAST_BIT);

endmodule

// File: ir_tracker_pkg.sv
`include "ir_tracker_config.svh"

package ir_tracker_pkg;

    // One sensor frame, seen as a flat word or as row bytes
    // Row 0 is the top byte, bit k of a row is column k
    typedef union packed {
        logic [`IR_BITS-1:0]                 flat;
        logic [0:`IR_ROWS-1][`IR_COLS-1:0]   rows;
    } sensor_frame_u;

    // Field layout of the POS register
    localparam int unsigned POS_X_LSB   = 0;
    localparam int unsigned POS_Y_LSB   = 4;
    localparam int unsigned POS_XY_W    = 4;   // Width of x and y
    localparam int unsigned POS_CNT_LSB = 8;
    localparam int unsigned POS_CNT_W   = 6;   // Holds 0 to 40
    localparam int unsigned POS_DET_BIT = 16;

    // Response codes on B and R
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// File: ir_tracker_config.svh
`ifndef IR_TRACKER_CONFIG_SVH
`define IR_TRACKER_CONFIG_SVH

// Sensor grid behind the shift register chain
`define IR_ROWS 5
`define IR_COLS 8
`define IR_BITS 40

// clk cycles per link tick, 2 or more
`define IR_TICK_DIV 4

// Host register bus
`define AXIL_ADDR_W 5
`define AXIL_DATA_W 32

// Register map, byte addresses
`define REG_CTRL      'h00
`define REG_POS       'h04
`define REG_FRAME_LO  'h08
`define REG_FRAME_HI  'h0C
`define REG_FRAME_CNT 'h10

`endif
